// File: hdl/line_buffer_consts.svh
// Line buffer constants
`ifndef LINE_BUFFER_CONSTS_SVH
`define LINE_BUFFER_CONSTS_SVH

// bits per rgb pixel
`define LB_PIX_WIDTH  24

// source image size in pixels
`define LB_IMG_WIDTH  16
`define LB_IMG_HEIGHT 8

// four window rows plus the line being written
`define LB_NUM_BANKS  5

// bicubic window is square
`define LB_WIN_SIZE   4

`endif

// File: hdl/line_buffer_pkg.sv
// Line buffer types
`default_nettype none

`include "line_buffer_consts.svh"

package line_buffer_pkg;

    typedef logic [`LB_PIX_WIDTH-1:0] pixel_t;

    typedef logic [$clog2(`LB_IMG_WIDTH)-1:0] col_addr_t;

    // in phase_k bank k takes the next line, banks k+1..k+4 hold rows 0..3
    typedef enum logic [2:0] {
        phase_fill = 3'd7,
        phase_0    = 3'd0,
        phase_1    = 3'd1,
        phase_2    = 3'd2,
        phase_3    = 3'd3,
        phase_4    = 3'd4
    } bank_phase_t;

    typedef logic [`LB_NUM_BANKS-1:0] bank_sel_t;

endpackage

`default_nettype wire

// File: hdl/line_sram.sv
// Single-port line SRAM
`default_nettype none

`include "line_buffer_consts.svh"

module line_sram #(
    parameter int DATA_WIDTH = `LB_PIX_WIDTH,
    parameter int DEPTH      = `LB_IMG_WIDTH
) (
    input  logic                       clk,
    input  logic                       cs,
    input  logic                       we,
    input  line_buffer_pkg::col_addr_t addr,
    input  logic [DATA_WIDTH-1:0]      din,
    output logic [DATA_WIDTH-1:0]      dout
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // read data is registered and holds while the bank is idle
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/line_writer.sv
// Input line writer
`default_nettype none

`include "line_buffer_consts.svh"

module line_writer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pix_valid,
    input  line_buffer_pkg::pixel_t    pix_data,
    output logic                       pix_ready,
    output logic                       wr_en,
    output line_buffer_pkg::col_addr_t wr_addr,
    output line_buffer_pkg::pixel_t    wr_data,
    output logic                       line_written,
    input  logic                       phase_advance
);

    import line_buffer_pkg::*;

    localparam int LINE_W = $clog2(`LB_IMG_HEIGHT + 1);
    localparam col_addr_t COL_LAST = col_addr_t'(`LB_IMG_WIDTH - 1);
    localparam logic [LINE_W-1:0] ALL_LINES = LINE_W'(`LB_IMG_HEIGHT);
    localparam logic [LINE_W-1:0] FILL_LINES = LINE_W'(`LB_WIN_SIZE);

    col_addr_t         col_cnt;
    logic [LINE_W-1:0] line_cnt;
    logic              line_full;
    logic              all_in;

    assign all_in       = (line_cnt == ALL_LINES);
    assign pix_ready    = !line_full && !all_in;
    assign line_written = line_full || all_in;

    assign wr_en   = pix_valid && pix_ready;
    assign wr_addr = col_cnt;
    assign wr_data = pix_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            line_cnt  <= '0;
            line_full <= 1'b0;
        end else if (wr_en) begin
            if (col_cnt == COL_LAST) begin
                col_cnt   <= '0;
                line_cnt  <= line_cnt + 1'b1;
                line_full <= 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end else if (phase_advance || (line_full && line_cnt < FILL_LINES)) begin
            // during the fill a finished line only pulses line_written
            line_full <= 1'b0;
        end
    end

    // the last pixel of a line closes the input
    a_line_end_blocks_input: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en && col_cnt == COL_LAST |=> !pix_ready
    );

endmodule

`default_nettype wire

// File: hdl/window_reader.sv
// Window band reader
`default_nettype none

`include "line_buffer_consts.svh"

module window_reader (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       phase_advance,
    input  logic                       in_band,
    output logic                       rd_en,
    output line_buffer_pkg::col_addr_t rd_addr,
    output logic                       shift_en,
    output logic                       band_done,
    output logic                       win_valid,
    input  logic                       win_ready,
    output logic                       done
);

    import line_buffer_pkg::*;

    // columns 0, 0, 1 .. W-1, W-1, W-1
    localparam int FETCHES = `LB_IMG_WIDTH + `LB_WIN_SIZE - 1;
    localparam int CNT_W   = $clog2(FETCHES + 1);
    localparam int BAND_W  = $clog2(`LB_IMG_HEIGHT - `LB_WIN_SIZE + 2);

    localparam logic [CNT_W-1:0]  FETCH_END = CNT_W'(FETCHES);
    localparam logic [CNT_W-1:0]  FIRST_WIN = CNT_W'(`LB_WIN_SIZE - 1);
    localparam logic [CNT_W-1:0]  COL_END   = CNT_W'(`LB_IMG_WIDTH);
    localparam logic [BAND_W-1:0] LAST_BAND = BAND_W'(`LB_IMG_HEIGHT - `LB_WIN_SIZE);

    logic [CNT_W-1:0]  fetch_cnt;
    logic [CNT_W-1:0]  shift_cnt;
    logic [BAND_W-1:0] band_cnt;
    logic              win_load;
    logic              stall;

    // the fourth and later shifts complete a window
    assign win_load = shift_en && (shift_cnt >= FIRST_WIN);

    // a fetch may only go out when its shift cannot overwrite a pending window
    assign stall = (win_valid && !win_ready) || win_load;
    assign rd_en = in_band && !done && (fetch_cnt != FETCH_END) && !stall;

    // clamp to the edge columns on both sides
    always_comb begin
        if (fetch_cnt == '0) begin
            rd_addr = '0;
        end else if (fetch_cnt > COL_END) begin
            rd_addr = col_addr_t'(`LB_IMG_WIDTH - 1);
        end else begin
            rd_addr = col_addr_t'(fetch_cnt - 1'b1);
        end
    end

    assign band_done = (fetch_cnt == FETCH_END) && (shift_cnt == FETCH_END)
                       && !win_valid && !done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cnt <= '0;
            shift_cnt <= '0;
            shift_en  <= 1'b0;
            win_valid <= 1'b0;
            band_cnt  <= '0;
            done      <= 1'b0;
        end else begin
            shift_en <= rd_en;
            if (phase_advance) begin
                fetch_cnt <= '0;
                shift_cnt <= '0;
            end else begin
                if (rd_en) begin
                    fetch_cnt <= fetch_cnt + 1'b1;
                end
                if (shift_en) begin
                    shift_cnt <= shift_cnt + 1'b1;
                end
            end
            if (win_load) begin
                win_valid <= 1'b1;
            end else if (win_ready) begin
                win_valid <= 1'b0;
            end
            // the advance out of the fill ends no band
            if (phase_advance && in_band) begin
                band_cnt <= band_cnt + 1'b1;
                if (band_cnt == LAST_BAND) begin
                    done <= 1'b1;
                end
            end
        end
    end

    a_hold_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        win_valid && !win_ready |-> !shift_en ##1 win_valid
    );

endmodule

`default_nettype wire

// File: hdl/bank_arbiter.sv
// Line bank arbiter
`default_nettype none

`include "line_buffer_consts.svh"

module bank_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_en,
    input  line_buffer_pkg::col_addr_t wr_addr,
    input  line_buffer_pkg::pixel_t    wr_data,
    input  logic                       rd_en,
    input  line_buffer_pkg::col_addr_t rd_addr,
    input  logic                       line_written,
    input  logic                       band_done,
    output logic                       phase_advance,
    output logic                       in_band,
    output line_buffer_pkg::pixel_t    tap_data [`LB_WIN_SIZE],
    output line_buffer_pkg::bank_sel_t bank_cs,
    output line_buffer_pkg::bank_sel_t bank_we,
    output line_buffer_pkg::col_addr_t bank_addr [`LB_NUM_BANKS],
    output line_buffer_pkg::pixel_t    bank_din [`LB_NUM_BANKS],
    input  line_buffer_pkg::pixel_t    bank_dout [`LB_NUM_BANKS]
);

    import line_buffer_pkg::*;

    bank_phase_t phase;
    bank_phase_t phase_next;
    logic [2:0]  fill_cnt;
    logic        lw_q;
    logic        lw_rise;
    logic [2:0]  wr_bank;
    bank_sel_t   wr_sel;

    assign lw_rise = line_written && !lw_q;
    assign in_band = (phase != phase_fill);

    // fill puts source lines 0..3 into banks 1..4, ready for phase_0
    assign wr_bank = in_band ? 3'(phase) : fill_cnt + 3'd1;
    assign wr_sel  = bank_sel_t'(1) << wr_bank;

    assign phase_advance = in_band ? (line_written && band_done)
                                   : (lw_rise && fill_cnt == 3'(`LB_WIN_SIZE - 1));

    always_comb begin
        case (phase)
            phase_0: phase_next = phase_1;
            phase_1: phase_next = phase_2;
            phase_2: phase_next = phase_3;
            phase_3: phase_next = phase_4;
            default: phase_next = phase_0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= phase_fill;
            fill_cnt <= '0;
            lw_q     <= 1'b0;
        end else begin
            lw_q <= line_written;
            if (lw_rise && !in_band) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (phase_advance) begin
                phase <= phase_next;
            end
        end
    end

    always_comb begin
        for (int b = 0; b < `LB_NUM_BANKS; b++) begin
            bank_cs[b]   = wr_sel[b] ? wr_en : rd_en;
            bank_we[b]   = wr_sel[b] && wr_en;
            bank_addr[b] = wr_sel[b] ? wr_addr : rd_addr;
            bank_din[b]  = wr_data;
        end
    end

    // window rows follow the write bank in rotated order
    always_comb begin
        int idx;
        for (int r = 0; r < `LB_WIN_SIZE; r++) begin
            idx = (int'(wr_bank) + 1 + r) % `LB_NUM_BANKS;
            tap_data[r] = bank_dout[idx];
        end
    end

    a_one_write_bank: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(wr_sel)
    );

endmodule

`default_nettype wire

// File: hdl/window_shift.sv
// 4x4 window shift registers
`default_nettype none

`include "line_buffer_consts.svh"

module window_shift (
    input  logic                    clk,
    input  logic                    shift_en,
    input  line_buffer_pkg::pixel_t tap_data [`LB_WIN_SIZE],
    output line_buffer_pkg::pixel_t window [`LB_WIN_SIZE*`LB_WIN_SIZE]
);

    localparam int N = `LB_WIN_SIZE;

    // row-major, column N-1 holds the newest fetch
    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N - 1; c++) begin
                    window[r*N + c] <= window[r*N + c + 1];
                end
                window[r*N + N - 1] <= tap_data[r];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/line_buffer_top.sv
// Bicubic line buffer top
`default_nettype none

`include "line_buffer_consts.svh"

module line_buffer_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pix_valid,
    input  line_buffer_pkg::pixel_t pix_data,
    output logic                    pix_ready,
    output logic                    win_valid,
    input  logic                    win_ready,
    output line_buffer_pkg::pixel_t window [`LB_WIN_SIZE*`LB_WIN_SIZE],
    output logic                    done
);

    import line_buffer_pkg::*;

    logic      wr_en;
    col_addr_t wr_addr;
    pixel_t    wr_data;
    logic      line_written;
    logic      rd_en;
    col_addr_t rd_addr;
    logic      shift_en;
    logic      band_done;
    logic      phase_advance;
    logic      in_band;
    pixel_t    tap_data [`LB_WIN_SIZE];
    bank_sel_t bank_cs;
    bank_sel_t bank_we;
    col_addr_t bank_addr [`LB_NUM_BANKS];
    pixel_t    bank_din [`LB_NUM_BANKS];
    pixel_t    bank_dout [`LB_NUM_BANKS];

    line_writer u_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .pix_ready     (pix_ready),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .line_written  (line_written),
        .phase_advance (phase_advance)
    );

    window_reader u_reader (
        .clk           (clk),
        .rst_n         (rst_n),
        .phase_advance (phase_advance),
        .in_band       (in_band),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .shift_en      (shift_en),
        .band_done     (band_done),
        .win_valid     (win_valid),
        .win_ready     (win_ready),
        .done          (done)
    );

    bank_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .line_written  (line_written),
        .band_done     (band_done),
        .phase_advance (phase_advance),
        .in_band       (in_band),
        .tap_data      (tap_data),
        .bank_cs       (bank_cs),
        .bank_we       (bank_we),
        .bank_addr     (bank_addr),
        .bank_din      (bank_din),
        .bank_dout     (bank_dout)
    );

    window_shift u_shift (
        .clk      (clk),
        .shift_en (shift_en),
        .tap_data (tap_data),
        .window   (window)
    );

    for (genvar b = 0; b < `LB_NUM_BANKS; b++) begin : g_bank
        line_sram #(
            .DATA_WIDTH (`LB_PIX_WIDTH),
            .DEPTH      (`LB_IMG_WIDTH)
        ) u_sram (
            .clk  (clk),
            .cs   (bank_cs[b]),
            .we   (bank_we[b]),
            .addr (bank_addr[b]),
            .din  (bank_din[b]),
            .dout (bank_dout[b])
        );
    end

endmodule

`default_nettype wire

// File: verification/tb_line_buffer.sv
// Line buffer testbench
`default_nettype none

`include "line_buffer_consts.svh"

module tb_line_buffer;

    import line_buffer_pkg::*;

    localparam int W               = `LB_IMG_WIDTH;
    localparam int H               = `LB_IMG_HEIGHT;
    localparam int N               = `LB_WIN_SIZE;
    localparam int BANDS           = H - N + 1;
    localparam int TOTAL_PIX       = W * H;
    localparam int TOTAL_WIN       = W * BANDS;
    localparam int WATCHDOG_CYCLES = 40 * W * H;

    logic   clk;
    logic   rst_n;
    logic   pix_valid;
    pixel_t pix_data;
    logic   pix_ready;
    logic   win_valid;
    logic   win_ready;
    pixel_t window [N*N];
    logic   done;

    logic [N*N*`LB_PIX_WIDTH-1:0] win_flat;
    pixel_t      image [H][W];
    logic [31:0] lfsr;
    int          pix_count = 0;
    int          win_idx = 0;
    int          band_idx = 0;
    int          win_total = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;

    line_buffer_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .window    (window),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] s;
        s = state >> 1;
        if (state[0]) begin
            s = s ^ 32'h80200003;
        end
        return s;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
        return value;
    endfunction

    function automatic int clamp_col(input int col);
        return (col < 0) ? 0 : ((col > W - 1) ? W - 1 : col);
    endfunction

    // window n of band b covers rows b..b+3 and columns n-1..n+2
    function automatic pixel_t expected_pixel(input int band, input int n, input int pos);
        return image[band + pos / N][clamp_col(n - 1 + pos % N)];
    endfunction

    always_comb begin
        for (int p = 0; p < N*N; p++) begin
            win_flat[p*`LB_PIX_WIDTH +: `LB_PIX_WIDTH] = window[p];
        end
    end

    // source side and sink side stimulus
    always @(posedge clk) begin
        int next_pix;
        if (rst_n) begin
            next_pix = pix_count + ((pix_valid && pix_ready) ? 1 : 0);
            // a pending pixel holds until it is accepted
            if (!pix_valid || pix_ready) begin
                if (next_pix < TOTAL_PIX) begin
                    pix_valid <= random_bits(1) != 0;
                    pix_data  <= image[next_pix / W][next_pix % W];
                end else begin
                    pix_valid <= 1'b0;
                end
            end
            win_ready <= random_bits(1) != 0;
        end
    end

    always @(posedge clk) begin
        if (rst_n && pix_valid && pix_ready) begin
            pix_count <= pix_count + 1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && win_valid && win_ready) begin
            assert (band_idx < BANDS) else begin
                protocol_errors++;
                $display("window transferred after the last band at time %0t", $time);
            end
            for (int p = 0; p < N*N; p++) begin
                assert (window[p] === expected_pixel(band_idx, win_idx, p)) else begin
                    value_errors++;
                    $display("Fail at time %0t: band %0d window %0d pixel %0d is %h, expected %h",
                             $time, band_idx, win_idx, p, window[p],
                             expected_pixel(band_idx, win_idx, p));
                end
            end
            win_total <= win_total + 1;
            if (win_idx == W - 1) begin
                win_idx  <= 0;
                band_idx <= band_idx + 1;
            end else begin
                win_idx <= win_idx + 1;
            end
        end
    end

    a_hold_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        win_valid && !win_ready |=> win_valid && $stable(win_flat)
    ) else begin
        protocol_errors++;
        $display("window changed or dropped while stalled at time %0t", $time);
    end

    a_done_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> done
    ) else begin
        protocol_errors++;
        $display("done fell after rising at time %0t", $time);
    end

    a_quiet_after_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> !win_valid
    ) else begin
        protocol_errors++;
        $display("window offered after done at time %0t", $time);
    end

    a_done_after_frame: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(done) |-> win_total == TOTAL_WIN
    ) else begin
        protocol_errors++;
        $display("done rose after %0d windows at time %0t", win_total, $time);
    end

    a_input_closed: assert property (
        @(posedge clk) disable iff (!rst_n)
        pix_count == TOTAL_PIX |-> !pix_ready
    ) else begin
        protocol_errors++;
        $display("input still ready after the whole frame at time %0t", $time);
    end

    initial begin
        lfsr = 32'h5d9712e6;
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                image[r][c] = pixel_t'(random_bits(`LB_PIX_WIDTH));
            end
        end
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        win_ready = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (pix_ready === 1'b1 && win_valid === 1'b0 && done === 1'b0) else begin
            protocol_errors++;
            $display("outputs not idle after reset at time %0t", $time);
        end
        wait (done === 1'b1);
        // let the sink keep toggling so a falling done would show
        repeat (4 * W) @(posedge clk);
        assert (win_total == TOTAL_WIN && band_idx == BANDS) else begin
            protocol_errors++;
            $display("saw %0d windows in %0d bands, expected %0d in %0d",
                     win_total, band_idx, TOTAL_WIN, BANDS);
        end
        assert (pix_count == TOTAL_PIX) else begin
            protocol_errors++;
            $display("accepted %0d pixels, expected %0d", pix_count, TOTAL_PIX);
        end
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles without done", WATCHDOG_CYCLES);
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: line_buffer.f
+incdir+hdl
hdl/line_buffer_pkg.sv
hdl/line_sram.sv
hdl/line_writer.sv
hdl/window_reader.sv
hdl/bank_arbiter.sv
hdl/window_shift.sv
hdl/line_buffer_top.sv
verification/tb_line_buffer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the line buffer testbench, fail if the log reports failure
verilator --binary --assert -f line_buffer.f --top-module tb_line_buffer -o sim_tb \
    && { ./obj_dir/sim_tb > sim.log 2>&1; cat sim.log; ! grep -q "TESTS FAILED" sim.log; } \
    && echo "simulation passed" \
    || { echo "simulation or build failed"; exit 1; }
